// File: logic/pager_defs.svh
`ifndef PAGER_DEFS_SVH
`define PAGER_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// port decode

// 7FFD partial decode on A15 and A1 only
`define PORT_7FFD_MASK   16'h8002
`define PORT_7FFD_MATCH  16'h0000

`define PORT_77          8'h77
`define PORT_F7          8'hF7
`define F7_HIGH_NIBBLE   4'hF

// high byte of the DOS entry trap
`define DOS_TRAP_HI      8'h3D

//////////////////////////////////////////////////////////////////////
// mapping

`define PENT_WIN1_PAGE   5
`define PENT_WIN2_PAGE   2
`define WIN_COUNT        4
`define PAGE_W           8
`define OFFS_W           14

`endif

// File: logic/zx_pkg.sv
`include "pager_defs.svh"

package zx_pkg;

	// one I/O write seen on the bus
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  data;
	} z80_io_wr_t;

	// one memory cycle with m1 set for opcode fetch
	typedef struct packed
	{
		logic [15:0] addr;
		logic        m1;
	} z80_mem_cyc_t;

	// 7FFD state plus pager enable from port 77
	typedef struct packed
	{
		logic [2:0] ram_page;
		logic       rom_sel;
		logic       lock;
		logic       pager_en;
	} pent_cfg_t;

	typedef struct packed
	{
		logic       is_ram;
		logic [6:0] ram_page;
	} atm_ram_view_t;

	typedef struct packed
	{
		logic       is_ram;
		logic       follow_dos;
		logic [3:0] unused;
		logic [1:0] rom_page;
	} atm_rom_view_t;

	// ATM page byte where bit 7 picks the view
	typedef union packed
	{
		atm_ram_view_t ram_view;
		atm_rom_view_t rom_view;
	} atm_page_u;

	typedef struct packed
	{
		logic               is_rom;
		logic [`PAGE_W-1:0] page;
		logic [`OFFS_W-1:0] offset;
	} mem_map_t;

endpackage

// File: logic/z80_bus_decode.sv
`timescale 1ns/1ps

module z80_bus_decode
	import zx_pkg::*;
(
	input  logic         fclk,
	input  logic         rst_n,
	input  logic [15:0]  a,
	input  logic [7:0]   d,
	input  logic         iorq_n,
	input  logic         mreq_n,
	input  logic         wr_n,
	input  logic         m1_n,
	input  logic         rfsh_n,
	output z80_io_wr_t   io_wr,
	output logic         io_stb,
	output z80_mem_cyc_t mem,
	output logic         mem_stb
);

	logic io_lvl;
	logic mem_lvl;
	logic io_q;
	logic mem_q;

	// m1_n high keeps interrupt acknowledge out
	assign io_lvl  = ~iorq_n & ~wr_n & m1_n;
	// refresh cycles are not memory accesses
	assign mem_lvl = ~mreq_n & rfsh_n;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			io_q    <= 1'b0;
			mem_q   <= 1'b0;
			io_stb  <= 1'b0;
			mem_stb <= 1'b0;
		end
		else
		begin
			io_q    <= io_lvl;
			mem_q   <= mem_lvl;
			io_stb  <= io_lvl & ~io_q;
			mem_stb <= mem_lvl & ~mem_q;
		end
	end

	// bus snapshot taken at the onset
	always_ff @(posedge fclk)
	begin
		if (io_lvl && !io_q)
		begin
			io_wr.addr <= a;
			io_wr.data <= d;
		end
		if (mem_lvl && !mem_q)
		begin
			mem.addr <= a;
			mem.m1   <= ~m1_n;
		end
	end

endmodule

// File: logic/port_regs.sv
`timescale 1ns/1ps

`include "pager_defs.svh"

module port_regs
	import zx_pkg::*;
(
	input  logic       fclk,
	input  logic       rst_n,
	input  z80_io_wr_t io_wr,
	input  logic       io_stb,
	output pent_cfg_t  pent
);

	logic hit_7ffd;
	logic hit_77;

	//////////////////////////////////////////////////////////////////////
	// address decode

	// partial decode mirrored over the whole A15=0 A1=0 space
	assign hit_7ffd = ((io_wr.addr & `PORT_7FFD_MASK) == `PORT_7FFD_MATCH);

	assign hit_77 = (io_wr.addr[7:0] == `PORT_77);

	//////////////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			pent <= '0;
		end
		else if (io_stb)
		begin
			// once locked, 7FFD is frozen until reset
			if (hit_7ffd && !pent.lock)
			begin
				pent.ram_page <= io_wr.data[2:0];
				pent.rom_sel  <= io_wr.data[4];
				pent.lock     <= io_wr.data[5];
			end
			if (hit_77)
			begin
				pent.pager_en <= io_wr.data[0];
			end
		end
	end

endmodule

// File: logic/atm_pager.sv
`timescale 1ns/1ps

`include "pager_defs.svh"

module atm_pager
	import zx_pkg::*;
#(
	parameter int WIN = 0
)
(
	input  logic       fclk,
	input  logic       rst_n,
	input  z80_io_wr_t io_wr,
	input  logic       io_stb,
	output atm_page_u  page
);

	logic hit;

	// xFF7 with the window picked by A15..A14
	assign hit = (io_wr.addr[7:0] == `PORT_F7) &&
	             (io_wr.addr[11:8] == `F7_HIGH_NIBBLE) &&
	             (io_wr.addr[15:14] == 2'(WIN));

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			page <= '0;
		end
		else if (io_stb && hit)
		begin
			page <= io_wr.data;
		end
	end

endmodule

// File: logic/dos_ctrl.sv
`timescale 1ns/1ps

`include "pager_defs.svh"

module dos_ctrl
	import zx_pkg::*;
(
	input  logic         fclk,
	input  logic         rst_n,
	input  z80_mem_cyc_t mem,
	input  logic         mem_stb,
	input  logic         fetch_rom,
	input  logic         fetch_basic,
	output logic         dos
);

	logic trap_hit;

	assign trap_hit = (mem.addr[15:8] == `DOS_TRAP_HI);

	// only opcode fetches move the flag
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			dos <= 1'b0;
		end
		else if (mem_stb && mem.m1)
		begin
			if (!fetch_rom)
				dos <= 1'b0;
			else if (trap_hit && fetch_basic)
				dos <= 1'b1;
		end
	end

endmodule

// File: logic/addr_map.sv
`timescale 1ns/1ps

`include "pager_defs.svh"

module addr_map
	import zx_pkg::*;
(
	input  logic         fclk,
	input  logic         rst_n,
	input  z80_mem_cyc_t mem,
	input  logic         mem_stb,
	input  pent_cfg_t    pent,
	input  atm_page_u    win_page [`WIN_COUNT],
	input  logic         dos,
	output mem_map_t     map,
	output logic         map_stb,
	output logic         fetch_rom,
	output logic         fetch_basic
);

	logic [1:0] win;
	atm_page_u  cur;
	mem_map_t   nxt;

	assign win = mem.addr[15:14];
	assign cur = win_page[win];

	//////////////////////////////////////////////////////////////////////
	// mapping of the cycle in progress

	always_comb
	begin
		nxt        = '0;
		nxt.offset = mem.addr[`OFFS_W-1:0];
		if (!pent.pager_en)
		begin
			case (win)
				2'd0:
				begin
					nxt.is_rom    = 1'b1;
					nxt.page[1:0] = {dos, pent.rom_sel};
				end
				2'd1: nxt.page = `PAGE_W'(`PENT_WIN1_PAGE);
				2'd2: nxt.page = `PAGE_W'(`PENT_WIN2_PAGE);
				default: nxt.page[2:0] = pent.ram_page;
			endcase
		end
		else if (cur.ram_view.is_ram)
		begin
			nxt.page[6:0] = cur.ram_view.ram_page;
		end
		else
		begin
			nxt.is_rom    = 1'b1;
			nxt.page[1:0] = cur.rom_view.rom_page;
			// dos picks between the paired ROMs
			if (cur.rom_view.follow_dos)
				nxt.page[0] = dos;
		end
	end

	assign fetch_rom   = nxt.is_rom;
	assign fetch_basic = nxt.page[0];

	//////////////////////////////////////////////////////////////////////
	// output register

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			map     <= '0;
			map_stb <= 1'b0;
		end
		else
		begin
			map_stb <= mem_stb;
			if (mem_stb)
				map <= nxt;
		end
	end

endmodule

// File: logic/zx_pager_top.sv
`timescale 1ns/1ps

`include "pager_defs.svh"

module zx_pager_top
	import zx_pkg::*;
(
	input  logic        fclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic        rfsh_n,
	output mem_map_t    map,
	output logic        map_stb,
	output logic        dos_n
);

	z80_io_wr_t   io_wr;
	logic         io_stb;
	z80_mem_cyc_t mem;
	logic         mem_stb;
	pent_cfg_t    pent;
	atm_page_u    win_page [`WIN_COUNT];
	logic         fetch_rom;
	logic         fetch_basic;
	logic         dos;

	assign dos_n = ~dos;

	z80_bus_decode bus_dec (
		.fclk(fclk), .rst_n(rst_n), .a(a), .d(d),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .wr_n(wr_n), .m1_n(m1_n), .rfsh_n(rfsh_n),
		.io_wr(io_wr), .io_stb(io_stb), .mem(mem), .mem_stb(mem_stb)
	);

	port_regs ports (
		.fclk(fclk), .rst_n(rst_n), .io_wr(io_wr), .io_stb(io_stb), .pent(pent)
	);

	// one pager per 16k window
	for (genvar i = 0; i < `WIN_COUNT; i++)
	begin : g_pager
		atm_pager #(.WIN(i)) pager (
			.fclk(fclk), .rst_n(rst_n), .io_wr(io_wr), .io_stb(io_stb), .page(win_page[i])
		);
	end

	addr_map mapper (
		.fclk(fclk), .rst_n(rst_n), .mem(mem), .mem_stb(mem_stb), .pent(pent),
		.win_page(win_page), .dos(dos), .map(map), .map_stb(map_stb),
		.fetch_rom(fetch_rom), .fetch_basic(fetch_basic)
	);

	dos_ctrl dosc (
		.fclk(fclk), .rst_n(rst_n), .mem(mem), .mem_stb(mem_stb),
		.fetch_rom(fetch_rom), .fetch_basic(fetch_basic), .dos(dos)
	);

endmodule

// File: tests/tb_zx_pager.sv
`timescale 1ns/1ps

module tb_zx_pager
	import zx_pkg::*;
();

	logic        fclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  d;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic        m1_n;
	logic        rfsh_n;
	mem_map_t    map;
	logic        map_stb;
	logic        dos_n;

	// reference state
	logic [2:0]  m_ram_page;
	logic        m_rom_sel;
	logic        m_lock;
	logic        m_pager_en;
	logic [7:0]  m_page [4];
	logic        m_dos;

	mem_map_t    exp_map_q [$];
	bit          exp_dos_n_q [$];
	mem_map_t    exp_map_now;
	bit          exp_dos_n_now;
	int          issued;
	int          checked;
	int          seed;
	logic [15:0] r16;
	logic [7:0]  r8;
	logic [2:0]  sel;

	zx_pager_top uut (
		.fclk(fclk), .rst_n(rst_n), .a(a), .d(d),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.m1_n(m1_n), .rfsh_n(rfsh_n),
		.map(map), .map_stb(map_stb), .dos_n(dos_n)
	);

	always #2 fclk = ~fclk;

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic void ref_io_write(input logic [15:0] addr, input logic [7:0] data);
		// 7FFD mirrors wherever A15 and A1 are low
		if (!addr[15] && !addr[1] && !m_lock)
		begin
			m_ram_page = data[2:0];
			m_rom_sel  = data[4];
			m_lock     = data[5];
		end
		if (addr[7:0] == 8'h77)
			m_pager_en = data[0];
		if (addr[7:0] == 8'hF7 && addr[11:8] == 4'hF)
			m_page[addr[15:14]] = data;
	endfunction

	function automatic mem_map_t ref_map(input logic [15:0] addr);
		mem_map_t   m;
		logic [7:0] pg;
		m        = '0;
		m.offset = addr[13:0];
		pg       = m_page[addr[15:14]];
		if (!m_pager_en)
		begin
			if (addr[15:14] == 2'd0)
			begin
				m.is_rom = 1'b1;
				m.page   = {6'd0, m_dos, m_rom_sel};
			end
			else if (addr[15:14] == 2'd1)
				m.page = 8'd5;
			else if (addr[15:14] == 2'd2)
				m.page = 8'd2;
			else
				m.page = {5'd0, m_ram_page};
		end
		else if (pg[7])
			m.page = {1'b0, pg[6:0]};
		else
		begin
			m.is_rom = 1'b1;
			m.page   = {6'd0, pg[1], pg[6] ? m_dos : pg[0]};
		end
		return m;
	endfunction

	function automatic void ref_dos_update(input logic [15:0] addr, input logic m1,
		input mem_map_t m);
		if (m1)
		begin
			if (!m.is_rom)
				m_dos = 1'b0;
			else if (addr[15:8] == 8'h3D && m.page[0])
				m_dos = 1'b1;
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_map(input mem_map_t got, input mem_map_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail map got %h expected %h", got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
	endtask

	always @(posedge fclk)
	begin
		if (rst_n && map_stb)
		begin
			if (exp_map_q.size() == 0)
				abort_run("map_stb seen with no memory cycle outstanding");
			else
			begin
				exp_map_now   = exp_map_q.pop_front();
				exp_dos_n_now = exp_dos_n_q.pop_front();
				check_map(map, exp_map_now);
				check_bit("dos_n", dos_n, exp_dos_n_now);
				checked++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus cycles start right after a rising edge

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		ref_io_write(addr, data);
		a      <= addr;
		d      <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		repeat (3) @(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
		repeat (2) @(posedge fclk);
	endtask

	task automatic mem_cycle(input logic [15:0] addr, input logic m1);
		mem_map_t exp;
		int       n;
		exp = ref_map(addr);
		exp_map_q.push_back(exp);
		// the cycle itself still maps with the old dos
		ref_dos_update(addr, m1, exp);
		exp_dos_n_q.push_back(~m_dos);
		issued++;
		a      <= addr;
		mreq_n <= 1'b0;
		rd_n   <= 1'b0;
		m1_n   <= ~m1;
		repeat (3) @(posedge fclk);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		m1_n   <= 1'b1;
		repeat (2) @(posedge fclk);
		n = 0;
		while (checked != issued)
		begin
			if (n == 50)
				abort_run("timeout, no map_stb within 50 cycles");
			@(posedge fclk);
			n++;
		end
	endtask

	// a refresh never produces map_stb
	task automatic refresh_cycle(input logic [15:0] addr);
		a      <= addr;
		mreq_n <= 1'b0;
		rfsh_n <= 1'b0;
		repeat (3) @(posedge fclk);
		mreq_n <= 1'b1;
		rfsh_n <= 1'b1;
		repeat (2) @(posedge fclk);
	endtask

	initial
	begin
		fclk       = 1'b0;
		rst_n      = 1'b0;
		a          = '0;
		d          = '0;
		iorq_n     = 1'b1;
		mreq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		m1_n       = 1'b1;
		rfsh_n     = 1'b1;
		m_ram_page = '0;
		m_rom_sel  = 1'b0;
		m_lock     = 1'b0;
		m_pager_en = 1'b0;
		m_dos      = 1'b0;
		for (int i = 0; i < 4; i++)
			m_page[i] = '0;
		issued  = 0;
		checked = 0;
		seed    = 83525;

		repeat (16) @(posedge fclk);
		check_map(map, '0);
		check_bit("map_stb", map_stb, 1'b0);
		check_bit("dos_n", dos_n, 1'b1);
		rst_n <= 1'b1;

		// pentagon mapping out of reset
		mem_cycle(16'h0123, 1'b0);
		mem_cycle(16'h4123, 1'b0);
		mem_cycle(16'h8123, 1'b0);
		mem_cycle(16'hC123, 1'b0);

		// 7ffd unlocked and then locked with rom_sel set
		for (int i = 0; i < 8; i++)
		begin
			r8    = 8'($random(seed));
			r8[5] = 1'b0;
			r16   = 16'($random(seed));
			io_write(i[0] ? 16'h7FFD : 16'h1FFD, r8);
			mem_cycle({2'b11, r16[13:0]}, 1'b0);
			mem_cycle({2'b00, r16[13:0]}, 1'b0);
		end
		io_write(16'h7FFD, 8'h36);
		for (int i = 0; i < 4; i++)
		begin
			io_write(16'h7FFD, 8'($random(seed)));
			mem_cycle(16'hC000 | 16'(i), 1'b0);
			mem_cycle(16'h0010 | 16'(i), 1'b0);
		end

		// dos trap followed by a clear from RAM and a plain read at 3Dxx
		mem_cycle(16'h3D2F, 1'b1);
		mem_cycle(16'h0100, 1'b0);
		mem_cycle(16'h8000, 1'b1);
		mem_cycle(16'h3D00, 1'b0);
		mem_cycle(16'h0100, 1'b0);

		io_write(16'h0077, 8'h01);
		// window pages out of reset read as ROM page 0
		for (int w = 0; w < 4; w++)
			mem_cycle({2'(w), 14'h0123}, 1'b0);

		// ATM pagers with RAM view on even rounds and ROM view on odd
		for (int w = 0; w < 4; w++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				r16   = 16'($random(seed));
				r8    = 8'($random(seed));
				r8[7] = ~k[0];
				io_write({2'(w), r16[13:12], 4'hF, 8'hF7}, r8);
				mem_cycle({2'(w), r16[13:0]}, 1'b0);
			end
		end

		// follow_dos on window 0
		io_write(16'h0FF7, 8'h01);
		mem_cycle(16'h3D10, 1'b1);
		io_write(16'h0FF7, 8'h42);
		mem_cycle(16'h0200, 1'b0);
		io_write(16'h8FF7, 8'h85);
		mem_cycle(16'h8004, 1'b1);
		mem_cycle(16'h0200, 1'b0);

		for (int i = 0; i < 300; i++)
		begin
			sel = 3'($random(seed));
			r16 = 16'($random(seed));
			r8  = 8'($random(seed));
			case (sel)
				3'd0: io_write({1'b0, r16[14:2], 1'b0, r16[0]}, r8);
				3'd1: io_write({r16[15:8], 8'h77}, r8);
				3'd2: io_write({r16[15:12], 4'hF, 8'hF7}, r8);
				3'd3: io_write(r16, r8);
				3'd4: mem_cycle({8'h3D, r16[7:0]}, 1'b1);
				3'd5: refresh_cycle(r16);
				default: mem_cycle(r16, r8[0]);
			endcase
		end

		if (exp_map_q.size() != 0 || checked != issued)
			abort_run("memory cycles left unchecked at the end of the run");
		else
		begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

// File: list.f
+incdir+logic
logic/zx_pkg.sv
logic/z80_bus_decode.sv
logic/port_regs.sv
logic/atm_pager.sv
logic/dos_ctrl.sv
logic/addr_map.sv
logic/zx_pager_top.sv
tests/tb_zx_pager.sv

// File: run.sh
#!/bin/sh
# build and run the zx pager testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f list.f \
	--top-module tb_zx_pager -o tb_zx_pager --Mdir obj_dir

# exit status of the simulation is the result
./obj_dir/tb_zx_pager
